//--- common/ahb_pkg.sv
// AHB-Lite package with transfer encodings and the request and response bundles.
`default_nettype none

`include "mbox_defs.svh"

package ahb_pkg;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_e;

    typedef enum logic [1:0] {
        OKAY  = 2'b00,
        ERROR = 2'b01
    } hresp_e;

    // Address phase signals from the manager.
    typedef struct packed {
        logic                hsel;
        logic [`MBOX_AW-1:0] haddr;
        logic [3:0]          hprot;
        hsize_e              hsize;
        htrans_e             htrans;
        logic [2:0]          hburst; // Incrementing bursts only.
        logic                hwrite;
    } ahb_req_t;

    // Data phase signals back to the manager.
    typedef struct packed {
        hresp_e              hresp;
        logic                hready;
        logic [`MBOX_DW-1:0] hrdata;
    } ahb_rsp_t;

endpackage

`default_nettype wire

//--- common/mbox_defs.svh
// Mailbox subsystem parameters for bus widths, RAM size and register map.
`ifndef MBOX_DEFS_SVH
`define MBOX_DEFS_SVH

// AHB-Lite bus widths.
`define MBOX_AW 32
`define MBOX_DW 32

// Shared message RAM of 8192 words of 32 bits.
`define MBOX_RAM_WORDS 8192

// Address bit that steers a transfer to the RAM bank.
`define MBOX_BANK_BIT 15

// Register page offsets sized to the bits below the bank bit.
`define MBOX_CTRL0_OFS 15'h0000
`define MBOX_CTRL1_OFS 15'h0004

`endif

//--- common/mbox_pkg.sv
// Mailbox package with the control register layout and the mailbox index.
`default_nettype none

package mbox_pkg;

    // Control word of one mailbox.
    typedef struct packed {
        logic        intr; // Interrupt request to the peer.
        logic        full; // Set while a message is waiting.
        logic [6:0]  rsvd;
        logic [14:0] size; // Message size in bytes.
        logic [7:0]  id;
    } mbox_ctrl_t;

    typedef enum logic {
        MBOX0 = 1'b0,
        MBOX1 = 1'b1
    } mbox_idx_e;

endpackage

`default_nettype wire

//--- hdl/mbox_top.sv
// Mailbox subsystem top level that connects the mailbox slave to the bus ports.
`default_nettype none

`include "mbox_defs.svh"

module mbox_top (
    input  logic                hclk_i,
    input  logic                hresetn_i,
    input  ahb_pkg::ahb_req_t   ahb_req_i,
    input  logic [`MBOX_DW-1:0] hwdata_i,
    output ahb_pkg::ahb_rsp_t   ahb_rsp_o,
    output logic                irq_o
);

    ahb_pkg::ahb_rsp_t mbox_rsp;
    logic              mbox_irq;

    ahb_mailbox u_mailbox (
        .hclk_i   (hclk_i),
        .hresetn_i(hresetn_i),
        .ahb_req_i(ahb_req_i),
        .hwdata_i (hwdata_i),
        .ahb_rsp_o(mbox_rsp),
        .irq_o    (mbox_irq)
    );

    assign ahb_rsp_o = mbox_rsp;
    assign irq_o     = mbox_irq; // Level interrupt to both processors.

endmodule

`default_nettype wire

//--- mailbox/ahb_mailbox.sv
// Mailbox slave with bank decode, two control registers, response mux and interrupt.
`default_nettype none

`include "mbox_defs.svh"

module ahb_mailbox (
    input  logic                hclk_i,
    input  logic                hresetn_i,
    input  ahb_pkg::ahb_req_t   ahb_req_i,
    input  logic [`MBOX_DW-1:0] hwdata_i,
    output ahb_pkg::ahb_rsp_t   ahb_rsp_o,
    output logic                irq_o
);

    logic                       xfer;
    logic                       bank_sel;
    logic [`MBOX_BANK_BIT-1:0]  reg_ofs;
    logic                       reg_hit;
    mbox_pkg::mbox_idx_e        reg_idx;
    logic                       reg_wr;
    logic                       reg_rd;
    logic [`MBOX_DW-1:0]        reg_rd_word;

    ahb_pkg::ahb_req_t          ram_req;
    ahb_pkg::ahb_rsp_t          ram_rsp;
    ahb_pkg::ahb_rsp_t          reg_rsp;

    mbox_pkg::mbox_ctrl_t       ctrl_q [2];
    logic                       bank_q;
    logic                       reg_wr_q;
    mbox_pkg::mbox_idx_e        wr_idx_q;
    logic [`MBOX_DW-1:0]        reg_rdata_q;

    // Hready is always high, so every valid address phase is accepted.
    assign xfer     = ahb_req_i.hsel &&
                      (ahb_req_i.htrans == ahb_pkg::NONSEQ ||
                       ahb_req_i.htrans == ahb_pkg::SEQ);
    assign bank_sel = ahb_req_i.haddr[`MBOX_BANK_BIT];
    assign reg_ofs  = ahb_req_i.haddr[`MBOX_BANK_BIT-1:0];

    always_comb begin
        reg_hit = (reg_ofs == `MBOX_CTRL0_OFS) || (reg_ofs == `MBOX_CTRL1_OFS);
        reg_idx = (reg_ofs == `MBOX_CTRL1_OFS) ? mbox_pkg::MBOX1 : mbox_pkg::MBOX0;
    end

    assign reg_wr = xfer & ~bank_sel & reg_hit & ahb_req_i.hwrite;
    assign reg_rd = xfer & ~bank_sel & ~ahb_req_i.hwrite;

    // Word seen by a register read, with a pending write forwarded.
    always_comb begin
        if (!reg_hit) begin
            reg_rd_word = '0; // Unmapped offsets read as zero.
        end else if (reg_wr_q && wr_idx_q == reg_idx) begin
            reg_rd_word = hwdata_i;
        end else begin
            reg_rd_word = ctrl_q[reg_idx];
        end
    end

    // The RAM only sees transfers to its own bank.
    always_comb begin
        ram_req      = ahb_req_i;
        ram_req.hsel = ahb_req_i.hsel & bank_sel;
    end

    ahb_ram #(
        .DEPTH(`MBOX_RAM_WORDS)
    ) u_ram (
        .hclk_i   (hclk_i),
        .hresetn_i(hresetn_i),
        .req_i    (ram_req),
        .hwdata_i (hwdata_i),
        .rsp_o    (ram_rsp)
    );

    always_ff @(posedge hclk_i or negedge hresetn_i) begin
        if (!hresetn_i) begin
            bank_q      <= 1'b0;
            reg_wr_q    <= 1'b0;
            wr_idx_q    <= mbox_pkg::MBOX0;
            reg_rdata_q <= '0;
        end else begin
            bank_q   <= xfer & bank_sel; // Selects the data phase response.
            reg_wr_q <= reg_wr;
            if (reg_wr) begin
                wr_idx_q <= reg_idx;
            end
            reg_rdata_q <= reg_rd ? reg_rd_word : '0;
        end
    end

    // Control registers load at the end of the write data phase.
    always_ff @(posedge hclk_i or negedge hresetn_i) begin
        if (!hresetn_i) begin
            ctrl_q[mbox_pkg::MBOX0] <= '0;
            ctrl_q[mbox_pkg::MBOX1] <= '0;
        end else if (reg_wr_q) begin
            ctrl_q[wr_idx_q] <= mbox_pkg::mbox_ctrl_t'(hwdata_i);
        end
    end

    always_comb begin
        reg_rsp.hresp  = ahb_pkg::OKAY;
        reg_rsp.hready = 1'b1;
        reg_rsp.hrdata = reg_rdata_q;
    end

    assign ahb_rsp_o = bank_q ? ram_rsp : reg_rsp;

    assign irq_o = ctrl_q[mbox_pkg::MBOX0].intr | ctrl_q[mbox_pkg::MBOX1].intr;

endmodule

`default_nettype wire

//--- mailbox/ahb_ram.sv
// Zero-wait AHB-Lite SRAM slave with byte-lane writes for message payloads.
`default_nettype none

`include "mbox_defs.svh"

module ahb_ram #(
    parameter int DEPTH = `MBOX_RAM_WORDS
) (
    input  logic                hclk_i,
    input  logic                hresetn_i,
    input  ahb_pkg::ahb_req_t   req_i,
    input  logic [`MBOX_DW-1:0] hwdata_i,
    output ahb_pkg::ahb_rsp_t   rsp_o
);

    localparam int IW = $clog2(DEPTH);

    logic                xfer;
    logic                wr;
    logic                rd;
    logic [IW-1:0]       idx;
    logic [3:0]          strb;
    logic [`MBOX_DW-1:0] rd_word;

    logic [`MBOX_DW-1:0] mem_q [DEPTH];
    logic                wr_q;
    logic [3:0]          strb_q;
    logic [IW-1:0]       widx_q;
    logic [`MBOX_DW-1:0] rdata_q;

    // Replace the strobed byte lanes of a word.
    function automatic logic [`MBOX_DW-1:0] merge_lanes(
        input logic [`MBOX_DW-1:0] old_word,
        input logic [`MBOX_DW-1:0] new_word,
        input logic [3:0]          lanes
    );
        logic [`MBOX_DW-1:0] word;
        word = old_word;
        for (int b = 0; b < 4; b++) begin
            if (lanes[b]) begin
                word[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return word;
    endfunction

    assign xfer = req_i.hsel &&
                  (req_i.htrans == ahb_pkg::NONSEQ || req_i.htrans == ahb_pkg::SEQ);
    assign wr   = xfer & req_i.hwrite;
    assign rd   = xfer & ~req_i.hwrite;
    assign idx  = req_i.haddr[IW+1:2]; // Word address.

    always_comb begin
        case (req_i.hsize)
            ahb_pkg::BYTE: strb = 4'b0001 << req_i.haddr[1:0];
            ahb_pkg::HALF: strb = req_i.haddr[1] ? 4'b1100 : 4'b0011;
            default:       strb = 4'b1111;
        endcase
    end

    // Forward a write still in its data phase.
    always_comb begin
        if (wr_q && widx_q == idx) begin
            rd_word = merge_lanes(mem_q[idx], hwdata_i, strb_q);
        end else begin
            rd_word = mem_q[idx];
        end
    end

    always_ff @(posedge hclk_i or negedge hresetn_i) begin
        if (!hresetn_i) begin
            wr_q <= 1'b0;
        end else begin
            wr_q <= wr;
        end
    end

    always_ff @(posedge hclk_i) begin
        if (wr) begin
            strb_q <= strb;
            widx_q <= idx;
        end
        if (rd) begin
            rdata_q <= rd_word;
        end
        if (wr_q) begin
            mem_q[widx_q] <= merge_lanes(mem_q[widx_q], hwdata_i, strb_q);
        end
    end

    always_comb begin
        rsp_o.hresp  = ahb_pkg::OKAY;
        rsp_o.hready = 1'b1;
        rsp_o.hrdata = rdata_q;
    end

endmodule

`default_nettype wire

//--- test/mbox_cases.txt
# Each line holds op, address, size, write data, expected read data and expected irq.
# Op is W, R or I. Size 0 is a byte, 1 a halfword, 2 a word. Values are hex.
R 00000000 2 00000000 00000000 0
R 00000004 2 00000000 00000000 0
W 00008000 2 11223344 00000000 0
W 00008004 2 55667788 00000000 0
W 0000fffc 2 deadbeef 00000000 0
R 00008000 2 00000000 11223344 0
R 00008004 2 00000000 55667788 0
R 0000fffc 2 00000000 deadbeef 0
W 00008100 2 cafef00d 00000000 0
R 00008100 2 00000000 cafef00d 0
# Byte and halfword lanes on top of a full word.
W 00008200 2 a5a5a5a5 00000000 0
W 00008201 0 00003c00 00000000 0
R 00008200 2 00000000 a5a53ca5 0
W 00008202 1 12340000 00000000 0
W 00008200 0 000000ff 00000000 0
R 00008200 2 00000000 12343cff 0
W 00008204 2 00000000 00000000 0
W 00008204 1 0000beef 00000000 0
W 00008207 0 7f000000 00000000 0
R 00008204 2 00000000 7f00beef 0
# Control registers and an unmapped offset.
W 00000000 2 40001203 00000000 0
R 00000000 2 00000000 40001203 0
R 00000004 2 00000000 00000000 0
W 00000004 2 40002a07 00000000 0
R 00000004 2 00000000 40002a07 0
R 00000000 2 00000000 40001203 0
W 00000008 2 ffffffff 00000000 0
R 00000008 2 00000000 00000000 0
R 00000000 2 00000000 40001203 0
# Interrupt from either mailbox.
W 00000000 2 c0001203 00000000 1
R 00000000 2 00000000 c0001203 1
W 00000004 2 c0002a07 00000000 1
W 00000000 2 00000000 00000000 1
R 00000004 2 00000000 c0002a07 1
W 00000004 2 00000000 00000000 0
R 00000004 2 00000000 00000000 0
# Idle cycles with write data on the bus.
I 00000000 2 ffffffff 00000000 0
I 00008000 2 00000000 00000000 0
I 00008200 2 ffffffff 00000000 0
R 00000000 2 00000000 00000000 0
R 00008000 2 00000000 11223344 0
R 00008200 2 00000000 12343cff 0
R 00008004 2 00000000 55667788 0

//--- test/tb_clock_gen.sv
// Testbench clock and reset source for the mailbox subsystem.
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic hclk_o,
    output logic hresetn_o
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        hclk_o = 1'b0;
        forever #(PERIOD_NS / 2) hclk_o = ~hclk_o;
    end

    // Reset is released on a falling edge, away from the sampling edge.
    initial begin
        hresetn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge hclk_o);
        @(negedge hclk_o);
        hresetn_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- test/tb_mbox_top.sv
// Testbench that replays AHB transfers from a case file into the mailbox subsystem.
`default_nettype none

`include "mbox_defs.svh"

module tb_mbox_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam string CASE_FILE = "test/mbox_cases.txt";

    logic                hclk;
    logic                hresetn;
    ahb_pkg::ahb_req_t   ahb_req;
    logic [`MBOX_DW-1:0] hwdata;
    ahb_pkg::ahb_rsp_t   ahb_rsp;
    logic                irq;

    // One entry per transfer line of the case file.
    byte                 op_q    [$];
    logic [31:0]         addr_q  [$];
    logic [2:0]          size_q  [$];
    logic [31:0]         wdata_q [$];
    logic [31:0]         rdata_q [$];
    logic                irq_q   [$];

    int                  n_cases      = 0;
    bit                  cases_loaded = 1'b0;
    int                  cycle_limit  = 0;
    int                  cycle_cnt    = 0;
    int                  rdata_errs   = 0;
    int                  irq_errs     = 0;
    int                  bus_errs     = 0;
    int                  file_errs    = 0;

    tb_clock_gen u_clk (
        .hclk_o   (hclk),
        .hresetn_o(hresetn)
    );

    mbox_top u_mbox_top (
        .hclk_i   (hclk),
        .hresetn_i(hresetn),
        .ahb_req_i(ahb_req),
        .hwdata_i (hwdata),
        .ahb_rsp_o(ahb_rsp),
        .irq_o    (irq)
    );

    task automatic load_cases();
        int          fd;
        int          got;
        string       line;
        string       op;
        logic [31:0] addr;
        logic [31:0] size;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [31:0] irq_exp;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the case file %s", CASE_FILE);
            file_errs++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() == 0 || line.getc(0) == "#") begin
                    continue; // Comment line.
                end
                got = $sscanf(line, "%s %h %h %h %h %h", op, addr, size, wdata, rdata, irq_exp);
                if (got <= 0) begin
                    continue; // Blank line.
                end
                if (got != 6) begin
                    $display("Case file line has only %0d of its six fields", got);
                    file_errs++;
                    continue;
                end
                if (op != "W" && op != "R" && op != "I") begin
                    $display("Case file line has an unknown operation %s", op);
                    file_errs++;
                    continue;
                end
                op_q.push_back(op.getc(0));
                addr_q.push_back(addr);
                size_q.push_back(size[2:0]);
                wdata_q.push_back(wdata);
                rdata_q.push_back(rdata);
                irq_q.push_back(irq_exp[0]);
            end
            $fclose(fd);
            if (op_q.size() == 0) begin
                $display("The case file holds no transfers");
                file_errs++;
            end
        end
        n_cases = op_q.size();
    endtask

    // Address phase of case k, or a deselected bus past the last case.
    task automatic drive_addr(input int k);
        ahb_req = '0;
        if (k < n_cases) begin
            ahb_req.hsel   = 1'b1;
            ahb_req.haddr  = addr_q[k];
            ahb_req.hprot  = 4'b0011;
            ahb_req.hsize  = ahb_pkg::hsize_e'(size_q[k]);
            ahb_req.hburst = 3'b000;
            ahb_req.hwrite = (op_q[k] != "R"); // Idle lines also raise hwrite.
            if (op_q[k] == "I") begin
                ahb_req.htrans = ahb_pkg::IDLE;
            end else begin
                ahb_req.htrans = ahb_pkg::NONSEQ;
            end
        end
    endtask

    // Checks the data phase read of case cyc-1 and the settled irq of case cyc-2.
    task automatic check_cycle(input int cyc);
        int rk;
        int ik;
        rk = cyc - 1;
        ik = cyc - 2;
        assert (ahb_rsp.hready === 1'b1) else begin
            $display("FAIL hready cycle %0d expected 0x1 actual 0x%0h", cyc, ahb_rsp.hready);
            bus_errs++;
        end
        assert (ahb_rsp.hresp === ahb_pkg::OKAY) else begin
            $display("FAIL hresp cycle %0d expected 0x0 actual 0x%0h", cyc, ahb_rsp.hresp);
            bus_errs++;
        end
        if (rk >= 0 && rk < n_cases && op_q[rk] == "R") begin
            assert (ahb_rsp.hrdata === rdata_q[rk]) else begin
                $display("FAIL hrdata case %0d addr 0x%08h expected 0x%08h actual 0x%08h",
                         rk, addr_q[rk], rdata_q[rk], ahb_rsp.hrdata);
                rdata_errs++;
            end
        end
        if (ik >= 0 && ik < n_cases) begin
            assert (irq === irq_q[ik]) else begin
                $display("FAIL irq_o case %0d expected 0x%0h actual 0x%0h",
                         ik, irq_q[ik], irq);
                irq_errs++;
            end
        end
    endtask

    initial begin : run
        int total;
        ahb_req = '0;
        hwdata  = '0;
        load_cases();
        cycle_limit  = 3 * n_cases + 20;
        cases_loaded = 1'b1;
        wait (hresetn === 1'b1);
        @(negedge hclk);
        // Write data of one case goes out with the address of the next case.
        for (int cyc = 0; cyc < n_cases + 2; cyc++) begin
            check_cycle(cyc);
            if (cyc >= 1 && cyc <= n_cases) begin
                hwdata = wdata_q[cyc-1];
            end else begin
                hwdata = '0;
            end
            drive_addr(cyc);
            @(negedge hclk);
        end
        total = rdata_errs + irq_errs + bus_errs + file_errs;
        $display("Error counts over %0d cases: hrdata %0d, irq_o %0d, bus %0d, case file %0d",
                 n_cases, rdata_errs, irq_errs, bus_errs, file_errs);
        if (total == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        wait (cases_loaded);
        while (cycle_cnt < cycle_limit) begin
            @(posedge hclk);
            cycle_cnt++;
        end
        $display("Timeout after %0d clock cycles before the last case was checked",
                 cycle_limit);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+common
common/ahb_pkg.sv
common/mbox_pkg.sv
mailbox/ahb_ram.sv
mailbox/ahb_mailbox.sv
hdl/mbox_top.sv
test/tb_clock_gen.sv
test/tb_mbox_top.sv
